/* sources.f */
cart_pkg.sv
rom_write_bridge.sv
cart_header_scan.sv
region_select.sv
bram_sync_fsm.sv
vmode_timer.sv
cart_loader_top.sv
tb_cart_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
	--top-module tb_cart_loader -o sim_cart_loader
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_cart_loader > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

/* tb_cart_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cart_loader
	import cart_pkg::*;
();

	localparam int NUM_CASES = 8;
	localparam logic [ROM_ADDR_W-1:0] ROM_LAST = 25'h3FE;

	// One table row with header contents, options and expected results
	typedef struct packed {
		logic [63:0] code;
		logic [23:0] letters;
		logic [1:0]  prio;
		logic        auto_on;
		logic [7:0]  fidx;
		region_t     exp_region;
		quirk_t      exp_quirks;
	} case_t;

	logic       clk_sys = 1'b0;
	logic       rst_n;
	load_bus_t  load;
	logic       cart_download, rom_wrack;
	logic [7:0] file_index;
	logic       region_auto, region_off, pal, ext_reset;
	logic [1:0] region_prio;
	logic       img_mounted, img_readonly, img_size_nz;
	logic       load_req, save_req, autosave, osd_open, bram_change, sd_ack;

	logic                  rom_wr, load_wait, region_set, bk_loading;
	logic                  busy_led, core_reset, new_vmode;
	logic [ROM_ADDR_W-1:0] rom_addr, rom_sz;
	logic [ROM_DATA_W-1:0] rom_din;
	region_t               region_req;
	quirk_t                quirks;
	sd_req_t               sd;

	case_t   tests [NUM_CASES];
	sd_req_t sd_log [$];
	int      sectors_done = 0;
	logic    exp_wr = 1'b0;
	integer  seed = 32'hdee5;

	always #50 clk_sys = ~clk_sys;

	cart_loader_top #(.BRAM_SECTORS(4), .VMODE_DELAY(200)) UUT (
		.clk_sys(clk_sys), .rst_n(rst_n), .load(load), .cart_download(cart_download),
		.file_index(file_index), .rom_wrack(rom_wrack), .region_auto(region_auto),
		.region_off(region_off), .region_prio(region_prio), .pal(pal),
		.ext_reset(ext_reset), .img_mounted(img_mounted), .img_readonly(img_readonly),
		.img_size_nz(img_size_nz), .load_req(load_req), .save_req(save_req),
		.autosave(autosave), .osd_open(osd_open), .bram_change(bram_change),
		.sd_ack(sd_ack), .rom_wr(rom_wr), .rom_addr(rom_addr), .rom_din(rom_din),
		.load_wait(load_wait), .rom_sz(rom_sz), .region_req(region_req),
		.region_set(region_set), .quirks(quirks), .sd(sd), .bk_loading(bk_loading),
		.busy_led(busy_led), .core_reset(core_reset), .new_vmode(new_vmode)
	);

	////////////////////
	// Reporting
	////////////////////

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "Run aborted");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			stop_with_failure("Value mismatch");
		end
	endtask

	////////////////////
	// Responders
	////////////////////

	// Memory side acknowledges after 0 to 3 cycles
	initial begin
		int delay;
		rom_wrack <= 1'b0;
		forever begin
			@(posedge clk_sys);
			if (rom_wr !== rom_wrack) begin
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(posedge clk_sys);
				rom_wrack <= rom_wr;
			end
		end
	end

	// SD image responder logs every sector request it serves
	initial begin
		sd_ack <= 1'b0;
		forever begin
			@(posedge clk_sys);
			if ((sd.rd || sd.wr) && !sd_ack) begin
				sd_log.push_back(sd);
				@(posedge clk_sys);
				sd_ack <= 1'b1;
				repeat (3) @(posedge clk_sys);
				sd_ack <= 1'b0;
				sectors_done++;
			end
		end
	end

	initial begin
		repeat (NUM_CASES * 2000 + 10000) @(posedge clk_sys);
		stop_with_failure("Watchdog expired before the tests finished");
	end

	////////////////////
	// Header image
	////////////////////

	function automatic case_t make_case(input logic [63:0] code, input logic [23:0] letters,
			input logic [1:0] prio, input logic auto_on, input logic [7:0] fidx,
			input region_t exp_region, input logic [7:0] exp_quirks);
		case_t c;
		c.code       = code;
		c.letters    = letters;
		c.prio       = prio;
		c.auto_on    = auto_on;
		c.fidx       = fidx;
		c.exp_region = exp_region;
		c.exp_quirks = exp_quirks;
		return c;
	endfunction

	// Product code sits at bytes 0x183..0x18A and region letters at 0x1F0..0x1F2
	function automatic logic [7:0] header_byte(input case_t c, input int a);
		if (a >= 'h183 && a <= 'h18A)
			return c.code[8*('h18A - a) +: 8];
		if (a >= 'h1F0 && a <= 'h1F2)
			return c.letters[8*('h1F2 - a) +: 8];
		return 8'(a ^ (a >> 8) ^ (a >> 16) ^ (a >> 24)) ^ 8'h3C;
	endfunction

	// Loader words are little endian
	function automatic logic [15:0] header_word(input case_t c, input int a);
		return {header_byte(c, a + 1), header_byte(c, a)};
	endfunction

	function automatic logic [ROM_ADDR_W-1:0] header_addr(input int k);
		case (k)
			5: return ADDR_ID_DONE;
			6: return ADDR_REGION_A;
			7: return ADDR_REGION_B;
			8: return ADDR_HDR_END;
			default: return ADDR_ID_FIRST + ROM_ADDR_W'(2 * k);
		endcase
	endfunction

	////////////////////
	// Loader
	////////////////////

	task automatic write_word(input logic [ROM_ADDR_W-1:0] a, input logic [15:0] d);
		int n;
		@(negedge clk_sys);
		check_value("load_wait", load_wait, 1'b0);
		@(posedge clk_sys);
		load.wr   <= 1'b1;
		load.addr <= a;
		load.data <= d;
		@(posedge clk_sys);
		load.wr <= 1'b0;
		exp_wr = ~exp_wr;
		@(negedge clk_sys);
		check_value("rom_wr", rom_wr, exp_wr);
		check_value("load_wait", load_wait, 1'b1);
		check_value("rom_addr", rom_addr, a);
		check_value("rom_din", rom_din, {d[7:0], d[15:8]});
		n = 0;
		while (load_wait) begin
			@(negedge clk_sys);
			n++;
			if (n > 20)
				stop_with_failure("load_wait never cleared after a ROM write");
		end
		check_value("rom_wr", rom_wr, exp_wr);
	endtask

	task automatic run_download(input int idx, input logic mount);
		case_t c;
		logic  exp_set;
		int    k;
		c = tests[idx];
		exp_set = c.auto_on ? 1'b1 : |c.fidx;
		@(posedge clk_sys);
		region_prio   <= c.prio;
		region_auto   <= c.auto_on;
		file_index    <= c.fidx;
		img_mounted   <= mount;
		cart_download <= 1'b1;
		exp_wr = 1'b0;
		// Let the acknowledge settle after rom_wr clears
		repeat (6) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("rom_wr", rom_wr, 1'b0);
		check_value("region_set", region_set, 1'b0);
		for (k = 0; k < 9; k++)
			write_word(header_addr(k), header_word(c, int'(header_addr(k))));
		@(negedge clk_sys);
		check_value("region_set", region_set, exp_set);
		check_value("region_req", region_req, c.exp_region);
		check_value("core_reset", core_reset, exp_set);
		write_word(ROM_LAST, 16'hA55A);
		@(posedge clk_sys);
		cart_download <= 1'b0;
		img_mounted   <= 1'b0;
		repeat (4) @(negedge clk_sys);
		check_value("rom_sz", rom_sz, ROM_LAST);
		check_value("rom_addr", rom_addr, ROM_LAST);
		check_value("quirks", quirks, c.exp_quirks);
		check_value("region_set", region_set, 1'b0);
	endtask

	////////////////////
	// Backup RAM
	////////////////////

	task automatic wait_sectors(input int target);
		int n;
		n = 0;
		while (sectors_done < target) begin
			@(negedge clk_sys);
			n++;
			if (n > 300)
				stop_with_failure("Backup RAM transfer did not finish in time");
		end
	endtask

	task automatic check_sectors(input int base, input logic is_rd);
		int i;
		check_value("sector count", sd_log.size() - base, 4);
		for (i = 0; i < 4; i++) begin
			check_value("sd.lba", sd_log[base + i].lba, i);
			check_value("sd.rd", sd_log[base + i].rd, is_rd);
			check_value("sd.wr", sd_log[base + i].wr, !is_rd);
		end
	endtask

	task automatic test_backup_load();
		int base;
		int done_base;
		int n;
		base = sd_log.size();
		done_base = sectors_done;
		run_download(0, 1'b1);
		n = 0;
		while (!bk_loading) begin
			@(negedge clk_sys);
			n++;
			if (n > 10)
				stop_with_failure("Backup RAM load did not start after the download");
		end
		while (bk_loading) begin
			check_value("core_reset", core_reset, 1'b1);
			@(negedge clk_sys);
			n++;
			if (n > 300)
				stop_with_failure("bk_loading stayed high too long");
		end
		check_value("sectors done", sectors_done - done_base, 4);
		check_value("sd strobes", {sd.rd, sd.wr}, 2'b00);
		check_value("core_reset", core_reset, 1'b0);
		check_sectors(base, 1'b1);
	endtask

	task automatic test_saves();
		int base;
		base = sd_log.size();
		@(posedge clk_sys);
		save_req <= 1'b1;
		@(posedge clk_sys);
		save_req <= 1'b0;
		wait_sectors(sectors_done + 4);
		repeat (3) @(negedge clk_sys);
		check_value("sd.wr", sd.wr, 1'b0);
		check_value("bk_loading", bk_loading, 1'b0);
		check_sectors(base, 1'b0);

		// Autosave waits for the OSD
		base = sd_log.size();
		@(posedge clk_sys);
		autosave    <= 1'b1;
		bram_change <= 1'b1;
		@(posedge clk_sys);
		bram_change <= 1'b0;
		@(negedge clk_sys);
		check_value("sav_pending", UUT.sav_pending, 1'b1);
		check_value("busy_led", busy_led, 1'b1);
		check_value("sd.wr", sd.wr, 1'b0);
		@(posedge clk_sys);
		osd_open <= 1'b1;
		wait_sectors(sectors_done + 4);
		@(posedge clk_sys);
		osd_open <= 1'b0;
		repeat (3) @(negedge clk_sys);
		check_value("sav_pending", UUT.sav_pending, 1'b0);
		check_value("busy_led", busy_led, 1'b0);
		check_sectors(base, 1'b0);
	endtask

	task automatic test_vmode();
		logic vm0;
		int   n;
		// Idle long enough for any earlier countdown to run out
		repeat (300) @(negedge clk_sys);
		vm0 = new_vmode;
		@(posedge clk_sys);
		pal <= ~pal;
		@(negedge clk_sys);
		n = 0;
		while (new_vmode === vm0 && n < 400) begin
			@(negedge clk_sys);
			n++;
		end
		if (n < 199 || n > 202) begin
			$display("new_vmode toggled after %0d cycles, outside 199 to 202", n);
			stop_with_failure("Video mode change came at the wrong time");
		end
		repeat (250) @(negedge clk_sys);
		check_value("new_vmode", new_vmode, !vm0);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int i;
		rst_n         <= 1'b0;
		load          <= '0;
		cart_download <= 1'b0;
		file_index    <= 8'h00;
		region_auto   <= 1'b0;
		region_off    <= 1'b0;
		region_prio   <= 2'd0;
		pal           <= 1'b0;
		ext_reset     <= 1'b0;
		img_mounted   <= 1'b0;
		img_readonly  <= 1'b0;
		img_size_nz   <= 1'b1;
		load_req      <= 1'b0;
		save_req      <= 1'b0;
		autosave      <= 1'b0;
		osd_open      <= 1'b0;
		bram_change   <= 1'b0;

		// Quirk bits from msb are sram eeprom noram fifo pier svp fmbusy schan
		tests[0] = make_case("T-081276", "JUE", 2'd0, 1'b1, 8'h00, US, 8'h80);
		tests[1] = make_case("MK-1215 ", "J  ", 2'd1, 1'b1, 8'h00, JP, 8'h40);
		tests[2] = make_case("T-68???-", "E  ", 2'd3, 1'b1, 8'h00, EU, 8'h01);
		tests[3] = make_case("MK-1229 ", "JE ", 2'd2, 1'b1, 8'h00, JP, 8'h04);
		tests[4] = make_case("T-35036 ", "U4 ", 2'd1, 1'b1, 8'h00, EU, 8'h02);
		tests[5] = make_case("GM-99999", "JU ", 2'd0, 1'b0, 8'h40, US, 8'h00);
		tests[6] = make_case("T-574023", "   ", 2'd2, 1'b1, 8'h00, US, 8'h08);
		tests[7] = make_case("T-89016 ", "UE ", 2'd3, 1'b0, 8'h00, JP, 8'h10);

		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		check_value("rom_wr", rom_wr, 1'b0);
		check_value("load_wait", load_wait, 1'b0);
		check_value("region_set", region_set, 1'b0);
		check_value("sd strobes", {sd.rd, sd.wr}, 2'b00);
		check_value("bk_loading", bk_loading, 1'b0);
		check_value("sav_pending", UUT.sav_pending, 1'b0);
		check_value("new_vmode", new_vmode, 1'b0);

		for (i = 0; i < NUM_CASES; i++)
			run_download(i, 1'b0);
		test_backup_load();
		test_saves();
		test_vmode();

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* cart_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top
	import cart_pkg::*;
#(
	parameter int unsigned BRAM_SECTORS = 128,
	parameter int unsigned VMODE_DELAY  = 5000000
) (
	input  wire                   clk_sys,
	input  wire                   rst_n,
	// Loader stream and ROM side
	input  wire load_bus_t        load,
	input  wire                   cart_download,
	input  wire [7:0]             file_index,
	input  wire                   rom_wrack,
	// Options
	input  wire                   region_auto,
	input  wire                   region_off,
	input  wire [1:0]             region_prio,
	input  wire                   pal,
	input  wire                   ext_reset,
	// SD image and backup RAM control
	input  wire                   img_mounted,
	input  wire                   img_readonly,
	input  wire                   img_size_nz,
	input  wire                   load_req,
	input  wire                   save_req,
	input  wire                   autosave,
	input  wire                   osd_open,
	input  wire                   bram_change,
	input  wire                   sd_ack,
	output logic                  rom_wr,
	output logic [ROM_ADDR_W-1:0] rom_addr,
	output logic [ROM_DATA_W-1:0] rom_din,
	output logic                  load_wait,
	output logic [ROM_ADDR_W-1:0] rom_sz,
	output region_t               region_req,
	output logic                  region_set,
	output quirk_t                quirks,
	output sd_req_t               sd,
	output logic                  bk_loading,
	output logic                  busy_led,
	output logic                  core_reset,
	output logic                  new_vmode
);

	hdr_flags_t hdr;
	logic       sav_pending;

	// Core stays in reset while the region settles or backup RAM loads
	assign core_reset = ext_reset | region_set | bk_loading;
	assign busy_led   = cart_download | sav_pending;

	rom_write_bridge u_bridge (
		.clk_sys(clk_sys), .rst_n(rst_n), .load(load), .cart_download(cart_download),
		.rom_wrack(rom_wrack), .rom_wr(rom_wr), .rom_addr(rom_addr), .rom_din(rom_din),
		.load_wait(load_wait), .rom_sz(rom_sz)
	);

	cart_header_scan u_scan (
		.clk_sys(clk_sys), .rst_n(rst_n), .load(load), .cart_download(cart_download),
		.hdr(hdr), .quirks(quirks)
	);

	region_select u_region (
		.clk_sys(clk_sys), .rst_n(rst_n), .hdr(hdr), .region_auto(region_auto),
		.region_off(region_off), .region_prio(region_prio), .file_index(file_index),
		.region_req(region_req), .region_set(region_set)
	);

	bram_sync_fsm #(.BRAM_SECTORS(BRAM_SECTORS)) u_bram (
		.clk_sys(clk_sys), .rst_n(rst_n), .cart_download(cart_download),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .img_size_nz(img_size_nz),
		.svp_quirk(quirks.svp), .load_req(load_req), .save_req(save_req),
		.autosave(autosave), .osd_open(osd_open), .bram_change(bram_change),
		.sd_ack(sd_ack), .sd(sd), .bk_loading(bk_loading), .sav_pending(sav_pending)
	);

	vmode_timer #(.VMODE_DELAY(VMODE_DELAY)) u_vmode (
		.clk_sys(clk_sys), .rst_n(rst_n), .pal(pal), .hold(core_reset | cart_download),
		.new_vmode(new_vmode)
	);

endmodule

`default_nettype wire

/* vmode_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module vmode_timer #(
	parameter int unsigned VMODE_DELAY = 5000000
) (
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  pal,
	input  wire  hold,
	output logic new_vmode
);

	localparam int CNT_W = $clog2(VMODE_DELAY + 1);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(VMODE_DELAY);

	logic [CNT_W-1:0] cnt;
	logic             pal_q;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt       <= '0;
			pal_q     <= 1'b0;
			new_vmode <= 1'b0;
		end else begin
			pal_q <= pal;
			// Any PAL change restarts the settle time
			if (hold || (pal_q != pal)) begin
				cnt <= RELOAD;
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
				if (cnt == CNT_W'(1))
					new_vmode <= ~new_vmode;
			end
		end
	end

	a_cnt_max: assert property (@(posedge clk_sys) disable iff (!rst_n) cnt <= RELOAD);

endmodule

`default_nettype wire

/* bram_sync_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module bram_sync_fsm
	import cart_pkg::*;
#(
	parameter int unsigned BRAM_SECTORS = 128
) (
	input  wire      clk_sys,
	input  wire      rst_n,
	input  wire      cart_download,
	input  wire      img_mounted,
	input  wire      img_readonly,
	input  wire      img_size_nz,
	input  wire      svp_quirk,
	input  wire      load_req,
	input  wire      save_req,
	input  wire      autosave,
	input  wire      osd_open,
	input  wire      bram_change,
	input  wire      sd_ack,
	output sd_req_t  sd,
	output logic     bk_loading,
	output logic     sav_pending
);

	typedef enum logic {IDLE, XFER} state_t;

	state_t state;
	logic   bk_ena;
	logic   dl_q, load_q, save_q, ack_q, change_q;
	logic   save_trig;
	logic   last_sector;

	// Pending autosave goes out when the OSD opens
	assign save_trig   = save_req | (sav_pending & osd_open);
	assign last_sector = (sd.lba == 32'(BRAM_SECTORS - 1));

	////////////////////
	// Enable and autosave
	////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
			change_q    <= 1'b0;
		end else begin
			change_q <= bram_change;
			if (cart_download && !dl_q)
				bk_ena <= 1'b0;
			// Save image gets mounted while the cartridge is still loading
			if (cart_download && img_mounted && !img_readonly && !svp_quirk)
				bk_ena <= 1'b1;

			if (bram_change && !change_q && !osd_open)
				sav_pending <= autosave;
			else if (state == XFER)
				sav_pending <= 1'b0;
		end
	end

	////////////////////
	// Sector sequencer
	////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			sd         <= '0;
			bk_loading <= 1'b0;
			dl_q       <= 1'b0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			dl_q   <= cart_download;
			load_q <= load_req;
			save_q <= save_trig;
			ack_q  <= sd_ack;

			if (sd_ack && !ack_q) begin
				sd.rd <= 1'b0;
				sd.wr <= 1'b0;
			end

			case (state)
				IDLE: begin
					if (dl_q && !cart_download && img_size_nz && bk_ena) begin
						state      <= XFER;
						bk_loading <= 1'b1;
						sd         <= '{lba: 32'd0, rd: 1'b1, wr: 1'b0};
					end else if (bk_ena && ((load_req && !load_q) || (save_trig && !save_q))) begin
						state      <= XFER;
						bk_loading <= load_req;
						sd         <= '{lba: 32'd0, rd: load_req, wr: ~load_req};
					end
				end
				XFER: begin
					// Next sector once the current one is released
					if (!sd_ack && ack_q) begin
						if (last_sector) begin
							state      <= IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd.lba <= sd.lba + 32'd1;
							sd.rd  <= bk_loading;
							sd.wr  <= ~bk_loading;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (!rst_n) !(sd.rd && sd.wr));
	a_lba_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		sd.lba < 32'(BRAM_SECTORS));

endmodule

`default_nettype wire

/* region_select.sv */
`timescale 1ns/1ps
`default_nettype none

module region_select
	import cart_pkg::*;
(
	input  wire              clk_sys,
	input  wire              rst_n,
	input  wire hdr_flags_t  hdr,
	input  wire              region_auto,
	input  wire              region_off,
	input  wire [1:0]        region_prio,
	input  wire [7:0]        file_index,
	output region_t          region_req,
	output logic             region_set
);

	logic rdy_q;
	logic rdy_rise;
	logic rdy_fall;

	assign rdy_rise = hdr.ready & ~rdy_q;
	assign rdy_fall = ~hdr.ready & rdy_q;

	// First letter found in priority order wins
	function automatic region_t pick_region(input logic [1:0] prio, input hdr_flags_t h);
		region_t r;
		case (prio)
			2'd0: r = h.u ? US : h.e ? EU : h.j ? JP : US;
			2'd1: r = h.e ? EU : h.u ? US : h.j ? JP : EU;
			2'd2: r = h.u ? US : h.j ? JP : h.e ? EU : US;
			default: r = h.j ? JP : h.u ? US : h.e ? EU : JP;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rdy_q      <= 1'b0;
			region_req <= JP;
			region_set <= 1'b0;
		end else begin
			rdy_q <= hdr.ready;

			if (rdy_rise && !region_off) begin
				if (region_auto) begin
					region_set <= 1'b1;
					region_req <= pick_region(region_prio, hdr);
				end else begin
					// Extension index carries the region in its top bits
					region_set <= |file_index;
					region_req <= region_t'(file_index[7:6]);
				end
			end

			if (rdy_fall)
				region_set <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* cart_header_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_header_scan
	import cart_pkg::*;
(
	input  wire             clk_sys,
	input  wire             rst_n,
	input  wire load_bus_t  load,
	input  wire             cart_download,
	output hdr_flags_t      hdr,
	output quirk_t          quirks
);

	logic        dl_q;
	logic        dl_rise;
	logic        dl_fall;
	logic        hdr_wr;
	logic [63:0] cart_id;

	assign dl_rise = cart_download & ~dl_q;
	assign dl_fall = ~cart_download & dl_q;
	assign hdr_wr  = load.wr & cart_download;

	// Region letter to {j, u, e}
	function automatic logic [2:0] region_bits(input logic [7:0] c);
		logic [2:0] b;
		b = 3'b000;
		if (c == "J")
			b = 3'b100;
		else if (c == "U")
			b = 3'b010;
		else if (c >= "0" && c <= "Z")
			b = 3'b001;
		return b;
	endfunction

	// Fixed title table, plain compare so '?' is a literal character
	function automatic quirk_t title_quirks(input logic [63:0] id);
		quirk_t q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				q.sram = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				q.eeprom = 1'b1;
			// Fake RAM check in the game
			"T-113016": q.noram = 1'b1;
			"T-89016 ": q.fifo = 1'b1;
			"T-574023", "T-574013": q.pier = 1'b1;
			"MK-1229 ", "G-7001  ": q.svp = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-": q.fmbusy = 1'b1;
			"T-68???-": q.schan = 1'b1;
			default: ;
		endcase
		return q;
	endfunction

	// Product code, bytes swapped into reading order
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			if (load.addr == ADDR_ID_FIRST)
				cart_id[63:56] <= load.data[15:8];
			if (load.addr == ADDR_ID_FIRST + 25'd2)
				cart_id[55:40] <= {load.data[7:0], load.data[15:8]};
			if (load.addr == ADDR_ID_FIRST + 25'd4)
				cart_id[39:24] <= {load.data[7:0], load.data[15:8]};
			if (load.addr == ADDR_ID_FIRST + 25'd6)
				cart_id[23:8] <= {load.data[7:0], load.data[15:8]};
			if (load.addr == ADDR_ID_LAST)
				cart_id[7:0] <= load.data[7:0];
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_q   <= 1'b0;
			hdr    <= '0;
			quirks <= '0;
		end else begin
			dl_q <= cart_download;

			if (dl_rise) begin
				{hdr.j, hdr.u, hdr.e} <= 3'b000;
				quirks                <= '0;
			end
			if (dl_fall)
				hdr.ready <= 1'b0;

			if (hdr_wr) begin
				if (load.addr == ADDR_REGION_A)
					{hdr.j, hdr.u, hdr.e} <= {hdr.j, hdr.u, hdr.e}
						| region_bits(load.data[7:0]) | region_bits(load.data[15:8]);
				if (load.addr == ADDR_REGION_B)
					{hdr.j, hdr.u, hdr.e} <= {hdr.j, hdr.u, hdr.e}
						| region_bits(load.data[7:0]);
				if (load.addr == ADDR_ID_DONE)
					quirks <= title_quirks(cart_id);
				if (load.addr == ADDR_HDR_END)
					hdr.ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rom_write_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_write_bridge
	import cart_pkg::*;
(
	input  wire                   clk_sys,
	input  wire                   rst_n,
	input  wire load_bus_t        load,
	input  wire                   cart_download,
	input  wire                   rom_wrack,
	output logic                  rom_wr,
	output logic [ROM_ADDR_W-1:0] rom_addr,
	output logic [ROM_DATA_W-1:0] rom_din,
	output logic                  load_wait,
	output logic [ROM_ADDR_W-1:0] rom_sz
);

	logic dl_q;
	logic dl_rise;
	logic dl_fall;

	assign dl_rise = cart_download & ~dl_q;
	assign dl_fall = ~cart_download & dl_q;

	// Write request toggles, memory side acknowledges by matching it
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_q      <= 1'b0;
			rom_wr    <= 1'b0;
			load_wait <= 1'b0;
			rom_sz    <= '0;
		end else begin
			dl_q <= cart_download;

			if (dl_fall) begin
				rom_sz    <= load.addr;
				load_wait <= 1'b0;
			end

			if (dl_rise) begin
				rom_wr <= 1'b0;
			end else if (cart_download) begin
				if (load.wr) begin
					load_wait <= 1'b1;
					rom_wr    <= ~rom_wr;
				end else if (load_wait && (rom_wr == rom_wrack)) begin
					load_wait <= 1'b0;
				end
			end
		end
	end

	// Image size takes over the address once loading is done
	assign rom_addr = cart_download ? load.addr : rom_sz;

	// Loader is little endian, ROM is big endian
	assign rom_din = {load.data[7:0], load.data[15:8]};

endmodule

`default_nettype wire

/* cart_pkg.sv */
`default_nettype none

package cart_pkg;

	////////////////////
	// Load path widths
	////////////////////

	localparam int ROM_ADDR_W = 25;
	localparam int ROM_DATA_W = 16;

	////////////////////
	// Header byte addresses
	////////////////////

	// Product code words, first and last
	localparam logic [ROM_ADDR_W-1:0] ADDR_ID_FIRST = 25'h182;
	localparam logic [ROM_ADDR_W-1:0] ADDR_ID_LAST  = 25'h18A;
	// Word after the product code, table lookup point
	localparam logic [ROM_ADDR_W-1:0] ADDR_ID_DONE  = 25'h18C;
	// Region letters
	localparam logic [ROM_ADDR_W-1:0] ADDR_REGION_A = 25'h1F0;
	localparam logic [ROM_ADDR_W-1:0] ADDR_REGION_B = 25'h1F2;
	localparam logic [ROM_ADDR_W-1:0] ADDR_HDR_END  = 25'h200;

	////////////////////
	// Shared types
	////////////////////

	// One loader beat
	typedef struct packed {
		logic                  wr;
		logic [ROM_ADDR_W-1:0] addr;
		logic [ROM_DATA_W-1:0] data;
	} load_bus_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
		logic ready;
	} hdr_flags_t;

	// Per-title compatibility flags
	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_t;

	// Backup RAM sector request towards the SD image
	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

endpackage

`default_nettype wire
